// ==== source/acc_cpu_cfg.svh ====
`ifndef ACC_CPU_CFG_SVH
`define ACC_CPU_CFG_SVH

// data and instruction word width
`define ACC_WORD_W 16

// opcode field at the top of every instruction
`define ACC_OP_W 6

// program and data memory share one address width
`define ACC_AW 8

// general registers r1..r4 and their index width
`define ACC_NUM_GPR 4
`define ACC_GPR_W 2

`endif

// ==== source/acc_cpu_pkg.sv ====
`include "acc_cpu_cfg.svh"

package acc_cpu_pkg;

    // instruction codes, anything unlisted runs as nop
    typedef enum logic [`ACC_OP_W-1:0] {
        OP_NOP    = 6'd0,
        OP_LDAC   = 6'd1,
        OP_LDIAC  = 6'd2,
        OP_STAC   = 6'd3,
        OP_MVACAR = 6'd4,
        OP_MVACR  = 6'd5,
        OP_MVACRN = 6'd6,
        OP_MVRNAC = 6'd7,
        OP_ADD    = 6'd8,
        OP_SUB    = 6'd9,
        OP_MUL    = 6'd10,
        OP_LSHIFT = 6'd11,
        OP_INAC   = 6'd12,
        OP_CLAC   = 6'd13,
        OP_JPNZ   = 6'd14,
        OP_JMPZ   = 6'd15,
        OP_END    = 6'd16
    } opcode_e;

    typedef struct packed {
        opcode_e                              opcode;
        logic [`ACC_WORD_W-`ACC_OP_W-1:0]     addr;  // only low ACC_AW bits used
    } mem_form_t;

    typedef struct packed {
        opcode_e                                        opcode;
        logic [`ACC_WORD_W-`ACC_OP_W-`ACC_GPR_W-1:0]    unused;
        logic [`ACC_GPR_W-1:0]                          gpr;
    } reg_form_t;

    // same ir word, decoded as address or register form
    typedef union packed {
        mem_form_t mem_form;
        reg_form_t reg_form;
    } instr_u;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH1, ST_FETCH2, ST_EXEC, ST_LD2, ST_ST2, ST_JMP2, ST_HALT
    } state_e;

    typedef enum logic [2:0] {
        BUS_NONE, BUS_PM, BUS_DM, BUS_IR_ADDR, BUS_AC, BUS_R, BUS_GPR
    } bus_src_e;

    typedef enum logic [2:0] {
        ALU_PASS, ALU_ADD, ALU_SUB, ALU_MUL, ALU_SHL
    } alu_op_e;

    typedef struct packed {
        bus_src_e              bus_src;
        logic                  ld_ir;
        logic                  ld_ar;
        logic                  ld_ac;
        logic                  ld_r;
        logic                  ld_gpr;
        logic                  ld_pc;
        logic                  inc_pc;
        logic                  inc_ac;
        logic                  clr_ac;
        logic                  alu_en;   // ac takes alu result instead of bus
        alu_op_e               alu_op;
        logic [`ACC_GPR_W-1:0] gpr_sel;
        logic                  dm_we;
    } ctrl_t;

endpackage

// ==== source/program_store.sv ====
`timescale 1ns/1ps
`include "acc_cpu_cfg.svh"

module program_store (
    input  logic                   clk,
    input  logic                   host_we,     // already qualified for this memory
    input  logic [`ACC_AW-1:0]     host_addr,
    input  logic [`ACC_WORD_W-1:0] host_wdata,
    input  logic [`ACC_AW-1:0]     pm_addr,
    output logic [`ACC_WORD_W-1:0] pm_data
);

    logic [`ACC_WORD_W-1:0] mem [2**`ACC_AW];

    // host load port
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
    end

    // fetch is asynchronous, ir captures it in fetch1
    assign pm_data = mem[pm_addr];

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  acc_cpu_pkg::instr_u ir,
    input  logic                ac_zero,
    output acc_cpu_pkg::ctrl_t  ctrl,
    output logic                busy,
    output logic                done
);

    acc_cpu_pkg::state_e  state;
    acc_cpu_pkg::state_e  next_state;
    acc_cpu_pkg::opcode_e op;
    logic                 take_branch;

    // alu operation for the four arithmetic opcodes
    function automatic acc_cpu_pkg::alu_op_e alu_for(input acc_cpu_pkg::opcode_e o);
        case (o)
            acc_cpu_pkg::OP_ADD:    return acc_cpu_pkg::ALU_ADD;
            acc_cpu_pkg::OP_SUB:    return acc_cpu_pkg::ALU_SUB;
            acc_cpu_pkg::OP_MUL:    return acc_cpu_pkg::ALU_MUL;
            acc_cpu_pkg::OP_LSHIFT: return acc_cpu_pkg::ALU_SHL;
            default:                return acc_cpu_pkg::ALU_PASS;
        endcase
    endfunction

    assign op = ir.mem_form.opcode;  // same bits in both forms
    assign take_branch = (op == acc_cpu_pkg::OP_JPNZ) ? !ac_zero : ac_zero;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= acc_cpu_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            acc_cpu_pkg::ST_IDLE: begin
                if (start) begin
                    next_state = acc_cpu_pkg::ST_FETCH1;
                end
            end
            acc_cpu_pkg::ST_FETCH1: next_state = acc_cpu_pkg::ST_FETCH2;
            acc_cpu_pkg::ST_FETCH2: next_state = acc_cpu_pkg::ST_EXEC;
            acc_cpu_pkg::ST_EXEC: begin
                case (op)
                    acc_cpu_pkg::OP_LDAC,
                    acc_cpu_pkg::OP_LDIAC: next_state = acc_cpu_pkg::ST_LD2;
                    acc_cpu_pkg::OP_STAC:  next_state = acc_cpu_pkg::ST_ST2;
                    acc_cpu_pkg::OP_JPNZ,
                    acc_cpu_pkg::OP_JMPZ: begin
                        next_state = take_branch ? acc_cpu_pkg::ST_JMP2
                                                 : acc_cpu_pkg::ST_FETCH1;
                    end
                    acc_cpu_pkg::OP_END:   next_state = acc_cpu_pkg::ST_HALT;
                    default:               next_state = acc_cpu_pkg::ST_FETCH1;
                endcase
            end
            acc_cpu_pkg::ST_LD2,
            acc_cpu_pkg::ST_ST2,
            acc_cpu_pkg::ST_JMP2:   next_state = acc_cpu_pkg::ST_FETCH1;
            default:                next_state = acc_cpu_pkg::ST_IDLE;  // halt returns here
        endcase
    end

    // control word, combinational from state and ir
    always_comb begin
        ctrl = '0;
        case (state)
            acc_cpu_pkg::ST_FETCH1: begin
                ctrl.bus_src = acc_cpu_pkg::BUS_PM;
                ctrl.ld_ir   = 1'b1;
            end
            acc_cpu_pkg::ST_FETCH2: ctrl.inc_pc = 1'b1;
            acc_cpu_pkg::ST_EXEC: begin
                case (op)
                    acc_cpu_pkg::OP_LDAC,
                    acc_cpu_pkg::OP_MVACAR: begin
                        ctrl.bus_src = acc_cpu_pkg::BUS_AC;
                        ctrl.ld_ar   = 1'b1;
                    end
                    acc_cpu_pkg::OP_LDIAC: begin
                        ctrl.bus_src = acc_cpu_pkg::BUS_IR_ADDR;
                        ctrl.ld_ar   = 1'b1;
                    end
                    acc_cpu_pkg::OP_STAC:  ctrl.bus_src = acc_cpu_pkg::BUS_AC;  // write in st2
                    acc_cpu_pkg::OP_MVACR: begin
                        ctrl.bus_src = acc_cpu_pkg::BUS_AC;
                        ctrl.ld_r    = 1'b1;
                    end
                    acc_cpu_pkg::OP_MVACRN: begin
                        ctrl.bus_src = acc_cpu_pkg::BUS_AC;
                        ctrl.ld_gpr  = 1'b1;
                        ctrl.gpr_sel = ir.reg_form.gpr;
                    end
                    acc_cpu_pkg::OP_MVRNAC: begin
                        ctrl.bus_src = acc_cpu_pkg::BUS_GPR;
                        ctrl.gpr_sel = ir.reg_form.gpr;
                        ctrl.ld_ac   = 1'b1;
                    end
                    acc_cpu_pkg::OP_ADD,
                    acc_cpu_pkg::OP_SUB,
                    acc_cpu_pkg::OP_MUL,
                    acc_cpu_pkg::OP_LSHIFT: begin
                        ctrl.bus_src = acc_cpu_pkg::BUS_R;  // r reaches the alu over the bus
                        ctrl.ld_ac   = 1'b1;
                        ctrl.alu_en  = 1'b1;
                        ctrl.alu_op  = alu_for(op);
                    end
                    acc_cpu_pkg::OP_INAC: ctrl.inc_ac = 1'b1;
                    acc_cpu_pkg::OP_CLAC: ctrl.clr_ac = 1'b1;
                    default: ;  // nop, branches and end only steer next_state
                endcase
            end
            acc_cpu_pkg::ST_LD2: begin
                ctrl.bus_src = acc_cpu_pkg::BUS_DM;
                ctrl.ld_ac   = 1'b1;
            end
            acc_cpu_pkg::ST_ST2: begin
                ctrl.bus_src = acc_cpu_pkg::BUS_AC;
                ctrl.dm_we   = 1'b1;
            end
            acc_cpu_pkg::ST_JMP2: begin
                ctrl.bus_src = acc_cpu_pkg::BUS_IR_ADDR;
                ctrl.ld_pc   = 1'b1;
            end
            acc_cpu_pkg::ST_HALT: ctrl.ld_pc = 1'b1;  // idle bus is zero, pc back to 0
            default: ;
        endcase
    end

    assign busy = (state != acc_cpu_pkg::ST_IDLE);
    assign done = (state == acc_cpu_pkg::ST_HALT);  // halt lasts exactly one cycle

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {acc_cpu_pkg::ST_IDLE, acc_cpu_pkg::ST_FETCH1, acc_cpu_pkg::ST_FETCH2,
                      acc_cpu_pkg::ST_EXEC, acc_cpu_pkg::ST_LD2, acc_cpu_pkg::ST_ST2,
                      acc_cpu_pkg::ST_JMP2, acc_cpu_pkg::ST_HALT})
        else $error("control_unit: illegal state %0d", state);

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("control_unit: done held for more than one cycle");

    // a run only begins from a start seen while idle
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> $past(start))
        else $error("control_unit: busy rose without an accepted start");

endmodule

// ==== source/datapath.sv ====
`timescale 1ns/1ps
`include "acc_cpu_cfg.svh"

module datapath (
    input  logic                   clk,
    input  logic                   reset,
    input  acc_cpu_pkg::ctrl_t     ctrl,
    input  logic [`ACC_WORD_W-1:0] pm_data,
    input  logic [`ACC_WORD_W-1:0] dm_rdata,
    output acc_cpu_pkg::instr_u    ir,
    output logic [`ACC_AW-1:0]     ar,
    output logic [`ACC_AW-1:0]     pc,
    output logic [`ACC_WORD_W-1:0] bus,
    output logic                   ac_zero
);

    logic [`ACC_WORD_W-1:0] ac;
    logic [`ACC_WORD_W-1:0] r;
    logic [`ACC_WORD_W-1:0] gpr [`ACC_NUM_GPR];
    logic [`ACC_WORD_W-1:0] alu_y;

    // internal bus mux
    always_comb begin
        bus = '0;
        case (ctrl.bus_src)
            acc_cpu_pkg::BUS_PM:      bus = pm_data;
            acc_cpu_pkg::BUS_DM:      bus = dm_rdata;
            acc_cpu_pkg::BUS_IR_ADDR: bus[$bits(ir.mem_form.addr)-1:0] = ir.mem_form.addr;
            acc_cpu_pkg::BUS_AC:      bus = ac;
            acc_cpu_pkg::BUS_R:       bus = r;
            acc_cpu_pkg::BUS_GPR:     bus = gpr[ctrl.gpr_sel];
            default: ;  // none drives zero
        endcase
    end

    // alu takes its second operand from the bus
    always_comb begin
        case (ctrl.alu_op)
            acc_cpu_pkg::ALU_ADD: alu_y = ac + bus;
            acc_cpu_pkg::ALU_SUB: alu_y = ac - bus;
            acc_cpu_pkg::ALU_MUL: alu_y = ac * bus;       // low half only
            acc_cpu_pkg::ALU_SHL: alu_y = ac << bus[3:0];
            default:              alu_y = bus;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ac <= '0;
            r  <= '0;
            ar <= '0;
            pc <= '0;
            for (int i = 0; i < `ACC_NUM_GPR; i++) begin
                gpr[i] <= '0;
            end
        end else begin
            if (ctrl.clr_ac) begin
                ac <= '0;
            end else if (ctrl.inc_ac) begin
                ac <= ac + 1'b1;
            end else if (ctrl.ld_ac) begin
                ac <= ctrl.alu_en ? alu_y : bus;
            end
            if (ctrl.ld_r)   r <= bus;
            if (ctrl.ld_ar)  ar <= bus[`ACC_AW-1:0];
            if (ctrl.ld_gpr) gpr[ctrl.gpr_sel] <= bus;
            if (ctrl.ld_pc) begin
                pc <= bus[`ACC_AW-1:0];  // jump target or zero on halt
            end else if (ctrl.inc_pc) begin
                pc <= pc + 1'b1;
            end
        end
    end

    // instruction register loads in fetch1
    always_ff @(posedge clk) begin
        if (ctrl.ld_ir) begin
            ir <= bus;
        end
    end

    assign ac_zero = (ac == '0);

    a_alu_operand: assert property (@(posedge clk) disable iff (reset)
        (ctrl.ld_ac && ctrl.alu_en) |-> (ctrl.bus_src != acc_cpu_pkg::BUS_NONE))
        else $error("datapath: alu result loaded with no operand on the bus");

endmodule

// ==== source/data_store.sv ====
`timescale 1ns/1ps
`include "acc_cpu_cfg.svh"

module data_store (
    input  logic                   clk,
    input  logic                   reset,
    input  acc_cpu_pkg::ctrl_t     ctrl,
    input  logic [`ACC_AW-1:0]     ar,
    input  logic [`ACC_WORD_W-1:0] bus,
    input  logic                   host_we,
    input  logic                   host_mem_sel,  // 0 program, 1 data
    input  logic [`ACC_AW-1:0]     host_addr,
    input  logic [`ACC_WORD_W-1:0] host_wdata,
    input  logic                   host_rd,
    input  logic [`ACC_AW-1:0]     host_rd_addr,
    output logic [`ACC_WORD_W-1:0] dm_rdata,
    output logic                   pm_host_we,
    output logic [`ACC_WORD_W-1:0] host_rd_data,
    output logic                   host_rd_valid
);

    logic [`ACC_WORD_W-1:0] mem [2**`ACC_AW];
    logic                   dm_host_we;

    // split host strobe between the memories
    assign pm_host_we = host_we & ~host_mem_sel;
    assign dm_host_we = host_we & host_mem_sel;

    always_ff @(posedge clk) begin
        if (ctrl.dm_we) begin
            mem[ar] <= bus;  // stac, st2
        end else if (dm_host_we) begin
            mem[host_addr] <= host_wdata;
        end
    end

    assign dm_rdata = mem[ar];

    // host read-back, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (host_rd) begin
            host_rd_data <= mem[host_rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            host_rd_valid <= 1'b0;
        end else begin
            host_rd_valid <= host_rd;
        end
    end

    // host loads only while the cpu is idle
    a_port_clash: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.dm_we && host_we))
        else $error("data_store: cpu store and host write in the same cycle");

endmodule

// ==== source/acc_cpu_top.sv ====
`timescale 1ns/1ps
`include "acc_cpu_cfg.svh"

module acc_cpu_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   host_we,
    input  logic                   host_mem_sel,
    input  logic [`ACC_AW-1:0]     host_addr,
    input  logic [`ACC_WORD_W-1:0] host_wdata,
    input  logic                   host_rd,
    input  logic [`ACC_AW-1:0]     host_rd_addr,
    output logic                   busy,
    output logic                   done,
    output logic [`ACC_WORD_W-1:0] host_rd_data,
    output logic                   host_rd_valid
);

    acc_cpu_pkg::ctrl_t     ctrl;
    acc_cpu_pkg::instr_u    ir;
    logic [`ACC_AW-1:0]     ar;
    logic [`ACC_AW-1:0]     pc;
    logic [`ACC_WORD_W-1:0] bus;
    logic                   ac_zero;
    logic [`ACC_WORD_W-1:0] pm_data;
    logic [`ACC_WORD_W-1:0] dm_rdata;
    logic                   pm_host_we;

    program_store program_store_inst (
        .clk        (clk),
        .host_we    (pm_host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .pm_addr    (pc),         // fetch address straight from pc
        .pm_data    (pm_data)
    );

    control_unit control_unit_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .ir      (ir),
        .ac_zero (ac_zero),
        .ctrl    (ctrl),
        .busy    (busy),
        .done    (done)
    );

    datapath datapath_inst (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .pm_data  (pm_data),
        .dm_rdata (dm_rdata),
        .ir       (ir),
        .ar       (ar),
        .pc       (pc),
        .bus      (bus),
        .ac_zero  (ac_zero)
    );

    data_store data_store_inst (
        .clk           (clk),
        .reset         (reset),
        .ctrl          (ctrl),
        .ar            (ar),
        .bus           (bus),
        .host_we       (host_we),
        .host_mem_sel  (host_mem_sel),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_rd       (host_rd),
        .host_rd_addr  (host_rd_addr),
        .dm_rdata      (dm_rdata),
        .pm_host_we    (pm_host_we),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid)
    );

endmodule

// ==== dv/acc_cpu_model.svh ====
`ifndef ACC_CPU_MODEL_SVH
`define ACC_CPU_MODEL_SVH

// instruction set model, register state carries over between runs like the dut
logic [`ACC_WORD_W-1:0] m_pm [2**`ACC_AW];
logic [`ACC_WORD_W-1:0] m_dm [2**`ACC_AW];
logic [`ACC_WORD_W-1:0] m_gpr [`ACC_NUM_GPR];
logic [`ACC_WORD_W-1:0] m_ac;
logic [`ACC_WORD_W-1:0] m_r;
logic [`ACC_AW-1:0]     m_ar;
logic [`ACC_AW-1:0]     m_pc;

task automatic model_reset();
    m_ac = '0;
    m_r  = '0;
    m_ar = '0;
    m_pc = '0;
    for (int i = 0; i < `ACC_NUM_GPR; i++) begin
        m_gpr[i] = '0;
    end
endtask

// runs from pc up to end, counts instructions and cycles from the start strobe
task automatic model_run(output int n_instr, output int n_cycles);
    logic [`ACC_WORD_W-1:0] w;
    logic [`ACC_OP_W-1:0]   op;
    logic                   halted;
    n_instr  = 0;
    n_cycles = 1;  // idle to fetch1
    halted   = 1'b0;
    while (!halted && n_instr < 4096) begin
        w    = m_pm[m_pc];
        op   = w[`ACC_WORD_W-1 -: `ACC_OP_W];
        m_pc = m_pc + 1'b1;
        n_instr++;
        n_cycles += 3;  // two fetch cycles and exec
        case (op)
            acc_cpu_pkg::OP_LDAC, acc_cpu_pkg::OP_LDIAC: begin
                m_ar = (op == acc_cpu_pkg::OP_LDAC) ? m_ac[`ACC_AW-1:0] : w[`ACC_AW-1:0];
                m_ac = m_dm[m_ar];
                n_cycles++;
            end
            acc_cpu_pkg::OP_STAC: begin
                m_dm[m_ar] = m_ac;  // stores go to ar
                n_cycles++;
            end
            acc_cpu_pkg::OP_MVACAR: m_ar = m_ac[`ACC_AW-1:0];
            acc_cpu_pkg::OP_MVACR:  m_r = m_ac;
            acc_cpu_pkg::OP_MVACRN: m_gpr[w[`ACC_GPR_W-1:0]] = m_ac;
            acc_cpu_pkg::OP_MVRNAC: m_ac = m_gpr[w[`ACC_GPR_W-1:0]];
            acc_cpu_pkg::OP_ADD:    m_ac = m_ac + m_r;
            acc_cpu_pkg::OP_SUB:    m_ac = m_ac - m_r;
            acc_cpu_pkg::OP_MUL:    m_ac = m_ac * m_r;  // wraps to 16 bits
            acc_cpu_pkg::OP_LSHIFT: m_ac = m_ac << m_r[3:0];
            acc_cpu_pkg::OP_INAC:   m_ac = m_ac + 1'b1;
            acc_cpu_pkg::OP_CLAC:   m_ac = '0;
            acc_cpu_pkg::OP_JPNZ, acc_cpu_pkg::OP_JMPZ: begin
                if ((m_ac != '0) == (op == acc_cpu_pkg::OP_JPNZ)) begin
                    m_pc = w[`ACC_AW-1:0];
                    n_cycles++;
                end
            end
            acc_cpu_pkg::OP_END: begin
                halted = 1'b1;
                m_pc   = '0;
            end
            default: ;  // unknown codes behave as nop
        endcase
    end
endtask

`endif

// ==== dv/acc_cpu_tb.sv ====
`timescale 1ns/1ps
`include "acc_cpu_cfg.svh"

module acc_cpu_tb;

    localparam int DEPTH     = 2**`ACC_AW;
    localparam int NUM_TESTS = 24;
    localparam int MAX_LEN   = 40;  // program body without the end word
    localparam int RD_SAMPLE = 16;
    // loads plus a worst case run at four cycles per word plus a full read-back
    localparam int TEST_CYCLES = (MAX_LEN + 1) + DEPTH + 4 * (MAX_LEN + 1) + 8 + 2 * DEPTH + 8;
    localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES + DEPTH + 2 * RD_SAMPLE + 200;

    // opcode mix per program kind in ten slots
    localparam logic [10*`ACC_OP_W-1:0] OP_MIX [4] = '{
        {acc_cpu_pkg::OP_LDIAC, acc_cpu_pkg::OP_MVACR, acc_cpu_pkg::OP_MVACRN,
         acc_cpu_pkg::OP_MVRNAC, acc_cpu_pkg::OP_MVACAR, acc_cpu_pkg::OP_STAC,
         acc_cpu_pkg::OP_INAC, 6'd63, acc_cpu_pkg::OP_MVRNAC, acc_cpu_pkg::OP_STAC},
        {acc_cpu_pkg::OP_LDIAC, acc_cpu_pkg::OP_MVACR, acc_cpu_pkg::OP_ADD,
         acc_cpu_pkg::OP_SUB, acc_cpu_pkg::OP_MUL, acc_cpu_pkg::OP_LSHIFT,
         acc_cpu_pkg::OP_INAC, acc_cpu_pkg::OP_CLAC, acc_cpu_pkg::OP_STAC,
         acc_cpu_pkg::OP_MVACAR},
        {acc_cpu_pkg::OP_LDAC, acc_cpu_pkg::OP_STAC, acc_cpu_pkg::OP_MVACAR,
         acc_cpu_pkg::OP_LDIAC, acc_cpu_pkg::OP_INAC, acc_cpu_pkg::OP_MVACR,
         acc_cpu_pkg::OP_ADD, acc_cpu_pkg::OP_NOP, acc_cpu_pkg::OP_LDAC, acc_cpu_pkg::OP_STAC},
        {acc_cpu_pkg::OP_JPNZ, acc_cpu_pkg::OP_JMPZ, acc_cpu_pkg::OP_STAC,
         acc_cpu_pkg::OP_CLAC, acc_cpu_pkg::OP_LDIAC, acc_cpu_pkg::OP_INAC,
         acc_cpu_pkg::OP_MVACAR, acc_cpu_pkg::OP_JPNZ, acc_cpu_pkg::OP_JMPZ, acc_cpu_pkg::OP_NOP}
    };

    logic                   clk;
    logic                   reset;
    logic                   start;
    logic                   host_we;
    logic                   host_mem_sel;
    logic [`ACC_AW-1:0]     host_addr;
    logic [`ACC_WORD_W-1:0] host_wdata;
    logic                   host_rd;
    logic [`ACC_AW-1:0]     host_rd_addr;
    logic                   busy;
    logic                   done;
    logic [`ACC_WORD_W-1:0] host_rd_data;
    logic                   host_rd_valid;

    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_cnt = 0;
    string cur_name = "startup";

    `include "acc_cpu_model.svh"

    acc_cpu_top acc_cpu_top_inst (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .host_we       (host_we),
        .host_mem_sel  (host_mem_sel),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_rd       (host_rd),
        .host_rd_addr  (host_rd_addr),
        .busy          (busy),
        .done          (done),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout: test %0d (%s) still running after %0d cycles",
                     tests_run + 1, cur_name, CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h got %h", name, exp, act);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($urandom % unsigned'(n));
    endfunction

    function automatic string kind_label(input int kind);
        case (kind)
            0:       return "load/move";
            1:       return "arithmetic";
            2:       return "indirect";
            default: return "branch";
        endcase
    endfunction

    task automatic check_idle();
        check_value("busy", 32'd0, 32'(busy));
        check_value("done", 32'd0, 32'(done));
        check_value("host_rd_valid", 32'd0, 32'(host_rd_valid));
    endtask

    // about one word in eight is zero so branches see a zero ac
    task automatic fill_data();
        logic [31:0] rnd;
        for (int i = 0; i < DEPTH; i++) begin
            rnd = $urandom;
            m_dm[i] = (rnd[2:0] == 3'd0) ? '0 : rnd[31:16];
        end
    endtask

    task automatic load_memory(input logic sel, input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            check_idle();
            host_we      = 1'b1;
            host_mem_sel = sel;
            host_addr    = `ACC_AW'(i);
            host_wdata   = sel ? m_dm[i] : m_pm[i];
        end
        @(negedge clk);
        host_we = 1'b0;
    endtask

    task automatic read_word(input logic [`ACC_AW-1:0] addr);
        @(negedge clk);
        check_idle();
        host_rd      = 1'b1;
        host_rd_addr = addr;
        @(negedge clk);
        host_rd = 1'b0;
        check_value("host_rd_valid", 32'd1, 32'(host_rd_valid));
        check_value($sformatf("host_rd_data[%02h]", addr), 32'(m_dm[addr]), 32'(host_rd_data));
    endtask

    // start strobe then count falling edges up to done
    task automatic run_program(output int cycles);
        @(negedge clk);
        check_value("busy", 32'd0, 32'(busy));
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 1;
        while (done !== 1'b1) begin
            check_value("busy", 32'd1, 32'(busy));
            start = (cycles == 2);  // stray start while busy
            @(negedge clk);
            cycles++;
        end
        start = 1'b0;
        @(negedge clk);
        check_value("done", 32'd0, 32'(done));
        check_value("busy", 32'd0, 32'(busy));
    endtask

    task automatic report_test(input int errs_before, input int n_instr, input int cycles);
        tests_run++;
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test %0d %s: %s, %0d instructions, %0d cycles", tests_run, cur_name,
                 (errors == errs_before) ? "pass" : "fail", n_instr, cycles);
    endtask

    task automatic run_test(input int kind);
        int                   len;
        int                   n_instr;
        int                   exp_cycles;
        int                   cycles;
        int                   errs_before;
        logic [31:0]          rnd;
        logic [`ACC_OP_W-1:0] op;
        errs_before = errors;
        cur_name    = kind_label(kind);
        len         = 8 + rand_below(MAX_LEN - 7);
        for (int i = 0; i < len; i++) begin
            rnd = $urandom;
            op  = OP_MIX[kind][rand_below(10) * `ACC_OP_W +: `ACC_OP_W];
            if (op == acc_cpu_pkg::OP_JPNZ || op == acc_cpu_pkg::OP_JMPZ) begin
                // forward target no further than the end word
                m_pm[i] = {op, rnd[1:0], `ACC_AW'(i + 1 + rand_below(len - i))};
            end else begin
                m_pm[i] = {op, rnd[`ACC_WORD_W-`ACC_OP_W-1:0]};
            end
        end
        m_pm[len] = {acc_cpu_pkg::OP_END, {(`ACC_WORD_W-`ACC_OP_W){1'b0}}};
        fill_data();
        load_memory(1'b0, len + 1);
        load_memory(1'b1, DEPTH);
        model_run(n_instr, exp_cycles);
        run_program(cycles);
        check_value("done cycle", 32'(exp_cycles), 32'(cycles));
        for (int a = 0; a < DEPTH; a++) begin
            read_word(`ACC_AW'(a));
        end
        report_test(errs_before, n_instr, cycles);
    endtask

    initial begin
        int errs_before;
        reset        = 1'b1;
        start        = 1'b0;
        host_we      = 1'b0;
        host_mem_sel = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        host_rd      = 1'b0;
        host_rd_addr = '0;
        void'($urandom(32'h3a9fe09c));
        model_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // preload data memory and read a sample back before any start
        errs_before = errors;
        cur_name    = "reset values";
        fill_data();
        load_memory(1'b1, DEPTH);
        for (int i = 0; i < RD_SAMPLE; i++) begin
            read_word(`ACC_AW'(rand_below(DEPTH)));
        end
        report_test(errs_before, 0, 0);

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t % 4);
        end

        $display("tests %0d, passed %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_run - tests_failed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+source
+incdir+dv
source/acc_cpu_pkg.sv
source/program_store.sv
source/control_unit.sv
source/datapath.sv
source/data_store.sv
source/acc_cpu_top.sv
dv/acc_cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= acc_cpu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
